//--- rtl/mac_axis_pkg.sv
package mac_axis_pkg;

    // ************************************************************************
    // Widths and sizes
    // ************************************************************************

    // User data path
    localparam int DATA_W = 32;
    localparam int KEEP_W = 4;

    // Legacy byte-enable code
    localparam int BE_W = 2;

    // Packet length as reported by the MAC status
    localparam int LEN_W = 16;

    // FCS bytes stripped from the reported length
    localparam int CRC_BYTES = 4;

    // Length queue
    localparam int LEN_FIFO_DEPTH = 16;
    localparam int LEN_PTR_W = $clog2(LEN_FIFO_DEPTH);

    // ************************************************************************
    // Encodings
    // ************************************************************************

    // Valid bytes in the last word, leading bytes first
    typedef enum logic [BE_W-1:0] {
        be_four  = 2'b00,
        be_three = 2'b11,
        be_two   = 2'b10,
        be_one   = 2'b01
    } mac_be_e;

    // Receive status error type, only rx_good queues a length
    typedef enum logic [2:0] {
        err_fifo_full = 3'b001,
        err_too_long  = 3'b010,
        err_crc       = 3'b011,
        rx_good       = 3'b100,
        err_too_short = 3'b101
    } rx_err_e;

    // Read sequencer
    typedef enum logic [1:0] {
        rd_idle = 2'b00,
        rd_read = 2'b01,
        rd_pop  = 2'b10
    } rd_state_e;

    // One legacy user-port word
    typedef struct packed {
        logic [DATA_W-1:0] data;
        mac_be_e           be;
        logic              sop;
        logic              eop;
    } mac_beat_t;

    // Receive status from the MAC
    typedef struct packed {
        logic             apply;
        rx_err_e          err_type;
        logic [LEN_W-1:0] length;
    } rx_status_t;

endpackage

//--- rtl/axis_tx_adapter.sv
`timescale 1ns/10ps

module axis_tx_adapter (
    input  logic                            Reset,
    input  logic                            MAC_rx_clk_div,
    input  logic [mac_axis_pkg::DATA_W-1:0] tx_mac_tdata,
    input  logic [mac_axis_pkg::KEEP_W-1:0] tx_mac_tkeep,
    input  logic                            tx_mac_tlast,
    input  logic                            tx_mac_tvalid,
    output logic                            tx_mac_tready,
    output mac_axis_pkg::mac_beat_t         mac_tx_beat,
    output logic                            mac_tx_wr,
    input  logic                            mac_tx_wa
);
    import mac_axis_pkg::*;

    logic    in_pkt;
    logic    beat_acc;
    mac_be_e be_code;

    // MAC write-available is the ready
    assign tx_mac_tready = mac_tx_wa;
    assign beat_acc      = tx_mac_tvalid && mac_tx_wa;
    assign mac_tx_wr     = beat_acc;

    // In-packet flag, a single-beat packet leaves it clear
    always_ff @(posedge Reset or posedge MAC_rx_clk_div) begin
        if (MAC_rx_clk_div) begin
            in_pkt <= 1'b0;
        end else if (beat_acc) begin
            in_pkt <= !tx_mac_tlast;
        end
    end

    // Leading-byte priority on tkeep
    always_comb begin
        casez (tx_mac_tkeep)
            4'b1110: be_code = be_three;
            4'b110?: be_code = be_two;
            4'b10??: be_code = be_one;
            default: be_code = be_four;
        endcase
    end

    // Legacy word
    always_comb begin
        mac_tx_beat.data = tx_mac_tdata;
        mac_tx_beat.be   = be_code;
        mac_tx_beat.sop  = !in_pkt;
        mac_tx_beat.eop  = tx_mac_tlast;
    end

    // Strobe only while the MAC has room
    a_wr_needs_wa: assert property (@(posedge Reset) disable iff (MAC_rx_clk_div)
        mac_tx_wr |-> mac_tx_wa);

    // Stalled beat stays offered until taken
    a_tx_hold: assert property (@(posedge Reset) disable iff (MAC_rx_clk_div)
        tx_mac_tvalid && !tx_mac_tready |=> tx_mac_tvalid);

endmodule

//--- rtl/axis_rx_adapter.sv
`timescale 1ns/10ps

module axis_rx_adapter (
    input  logic                            Reset,
    input  logic                            MAC_rx_clk_div,
    input  mac_axis_pkg::mac_beat_t         mac_rx_beat,
    input  logic                            mac_rx_pa,
    output logic                            mac_rx_rd,
    input  logic                            len_avail,
    input  logic [mac_axis_pkg::LEN_W-1:0]  head_len,
    output logic                            len_pop,
    output logic [mac_axis_pkg::DATA_W-1:0] rx_mac_tdata,
    output logic [mac_axis_pkg::KEEP_W-1:0] rx_mac_tkeep,
    output logic [mac_axis_pkg::LEN_W-1:0]  rx_mac_tuser,
    output logic                            rx_mac_tlast,
    output logic                            rx_mac_tvalid,
    input  logic                            rx_mac_tready
);
    import mac_axis_pkg::*;

    rd_state_e state;
    logic      beat_acc;
    logic      first_beat;

    // ************************************************************************
    // Read sequencer
    // ************************************************************************

    // Word handed over to the user side
    assign beat_acc = (state == rd_read) && mac_rx_pa && rx_mac_tready;

    always_ff @(posedge Reset or posedge MAC_rx_clk_div) begin
        if (MAC_rx_clk_div) begin
            state <= rd_idle;
        end else begin
            case (state)
                rd_idle: begin
                    // Stored packet waiting
                    if (len_avail) begin
                        state <= rd_read;
                    end
                end
                rd_read: begin
                    if (beat_acc && mac_rx_beat.eop) begin
                        state <= rd_pop;
                    end
                end
                rd_pop: begin
                    state <= rd_idle;
                end
                default: begin
                    state <= rd_idle;
                end
            endcase
        end
    end

    // Read strobe follows tready, so stalls lose nothing
    assign mac_rx_rd = (state == rd_read) && rx_mac_tready;

    // Drop head length once the packet is out
    assign len_pop = (state == rd_pop);

    // Tracks the frame boundary for the sop check
    always_ff @(posedge Reset or posedge MAC_rx_clk_div) begin
        if (MAC_rx_clk_div) begin
            first_beat <= 1'b1;
        end else if (beat_acc) begin
            first_beat <= mac_rx_beat.eop;
        end
    end

    // ************************************************************************
    // Legacy to AXI-stream
    // ************************************************************************

    assign rx_mac_tdata  = mac_rx_beat.data;
    assign rx_mac_tlast  = mac_rx_beat.eop;
    assign rx_mac_tvalid = mac_rx_pa;
    assign rx_mac_tuser  = head_len;

    // Byte-enable code to tkeep
    always_comb begin
        case (mac_rx_beat.be)
            be_three: rx_mac_tkeep = 4'b1110;
            be_two:   rx_mac_tkeep = 4'b1100;
            be_one:   rx_mac_tkeep = 4'b1000;
            default:  rx_mac_tkeep = 4'b1111;
        endcase
    end

    // FWFT MAC only presents data when read
    a_pa_with_rd: assert property (@(posedge Reset) disable iff (MAC_rx_clk_div)
        mac_rx_pa |-> mac_rx_rd);

    // Frames start with sop
    a_first_sop: assert property (@(posedge Reset) disable iff (MAC_rx_clk_div)
        beat_acc && first_beat |-> mac_rx_beat.sop);

    // Head length fixed while its packet drains
    a_head_stable: assert property (@(posedge Reset) disable iff (MAC_rx_clk_div)
        state == rd_read |-> $stable(head_len));

endmodule

//--- rtl/rx_length_queue.sv
`timescale 1ns/10ps

module rx_length_queue (
    input  logic                           Reset,
    input  logic                           MAC_rx_clk_div,
    input  mac_axis_pkg::rx_status_t       mac_rx_status,
    input  logic                           rx_append_crc,
    input  logic                           len_pop,
    output logic                           len_avail,
    output logic [mac_axis_pkg::LEN_W-1:0] head_len
);
    import mac_axis_pkg::*;

    logic                 good_q;
    logic                 good_q1;
    logic                 wr_en;
    logic                 good_now;
    logic [LEN_W-1:0]     len_adj;
    logic [LEN_W-1:0]     len_s1;
    logic [LEN_PTR_W:0]   wr_ptr;
    logic [LEN_PTR_W:0]   rd_ptr;
    logic                 full;
    logic                 empty;
    logic [LEN_W-1:0]     mem [LEN_FIFO_DEPTH];

    // ************************************************************************
    // Good-frame qualification
    // ************************************************************************

    assign good_now = mac_rx_status.apply && (mac_rx_status.err_type == rx_good);

    // Strip the FCS unless the MAC keeps it in the data
    assign len_adj = rx_append_crc ? mac_rx_status.length :
                     mac_rx_status.length - LEN_W'(CRC_BYTES);

    // Two-stage edge detect, one write per apply pulse
    always_ff @(posedge Reset or posedge MAC_rx_clk_div) begin
        if (MAC_rx_clk_div) begin
            good_q  <= 1'b0;
            good_q1 <= 1'b0;
            wr_en   <= 1'b0;
        end else begin
            good_q  <= good_now;
            good_q1 <= good_q;
            wr_en   <= good_q && !good_q1;
        end
    end

    // Length sampled on the first apply cycle
    always_ff @(posedge Reset) begin
        if (good_now && !good_q) begin
            len_s1 <= len_adj;
        end
    end

    // ************************************************************************
    // Circular queue
    // ************************************************************************

    // Extra pointer bit tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[LEN_PTR_W] != rd_ptr[LEN_PTR_W]) &&
                   (wr_ptr[LEN_PTR_W-1:0] == rd_ptr[LEN_PTR_W-1:0]);

    always_ff @(posedge Reset or posedge MAC_rx_clk_div) begin
        if (MAC_rx_clk_div) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            // Full queue drops the write
            if (wr_en && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (len_pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge Reset) begin
        if (wr_en && !full) begin
            mem[wr_ptr[LEN_PTR_W-1:0]] <= len_s1;
        end
    end

    // Head entry falls through
    assign head_len  = mem[rd_ptr[LEN_PTR_W-1:0]];
    assign len_avail = !empty;

    // More good frames than queue entries
    a_no_overflow: assert property (@(posedge Reset) disable iff (MAC_rx_clk_div)
        wr_en |-> !full);

    // Sequencer pops only a queued length
    a_no_underflow: assert property (@(posedge Reset) disable iff (MAC_rx_clk_div)
        len_pop |-> !empty);

endmodule

//--- rtl/mac_axis.sv
`timescale 1ns/10ps

module mac_axis (
    input  logic                            Reset,
    input  logic                            MAC_rx_clk_div,
    // Transmit AXI-stream slave
    input  logic [mac_axis_pkg::DATA_W-1:0] tx_mac_tdata,
    input  logic [mac_axis_pkg::KEEP_W-1:0] tx_mac_tkeep,
    input  logic                            tx_mac_tlast,
    input  logic                            tx_mac_tvalid,
    output logic                            tx_mac_tready,
    // Receive AXI-stream master
    output logic [mac_axis_pkg::DATA_W-1:0] rx_mac_tdata,
    output logic [mac_axis_pkg::KEEP_W-1:0] rx_mac_tkeep,
    output logic [mac_axis_pkg::LEN_W-1:0]  rx_mac_tuser,
    output logic                            rx_mac_tlast,
    output logic                            rx_mac_tvalid,
    input  logic                            rx_mac_tready,
    // Legacy MAC transmit port
    output mac_axis_pkg::mac_beat_t         mac_tx_beat,
    output logic                            mac_tx_wr,
    input  logic                            mac_tx_wa,
    // Legacy MAC receive port
    input  mac_axis_pkg::mac_beat_t         mac_rx_beat,
    input  logic                            mac_rx_pa,
    output logic                            mac_rx_rd,
    // MAC receive status
    input  mac_axis_pkg::rx_status_t        mac_rx_status,
    // Config
    input  logic                            rx_append_crc
);
    import mac_axis_pkg::*;

    // Length queue to read sequencer
    logic             len_avail;
    logic [LEN_W-1:0] head_len;
    logic             len_pop;

    // ************************************************************************
    // Transmit path
    // ************************************************************************

    axis_tx_adapter axis_tx_adapter_inst (
        .Reset          (Reset),
        .MAC_rx_clk_div (MAC_rx_clk_div),
        .tx_mac_tdata   (tx_mac_tdata),
        .tx_mac_tkeep   (tx_mac_tkeep),
        .tx_mac_tlast   (tx_mac_tlast),
        .tx_mac_tvalid  (tx_mac_tvalid),
        .tx_mac_tready  (tx_mac_tready),
        .mac_tx_beat    (mac_tx_beat),
        .mac_tx_wr      (mac_tx_wr),
        .mac_tx_wa      (mac_tx_wa)
    );

    // ************************************************************************
    // Receive path
    // ************************************************************************

    // Lengths of good frames, head is tuser
    rx_length_queue rx_length_queue_inst (
        .Reset          (Reset),
        .MAC_rx_clk_div (MAC_rx_clk_div),
        .mac_rx_status  (mac_rx_status),
        .rx_append_crc  (rx_append_crc),
        .len_pop        (len_pop),
        .len_avail      (len_avail),
        .head_len       (head_len)
    );

    // Drains one stored packet per queued length
    axis_rx_adapter axis_rx_adapter_inst (
        .Reset          (Reset),
        .MAC_rx_clk_div (MAC_rx_clk_div),
        .mac_rx_beat    (mac_rx_beat),
        .mac_rx_pa      (mac_rx_pa),
        .mac_rx_rd      (mac_rx_rd),
        .len_avail      (len_avail),
        .head_len       (head_len),
        .len_pop        (len_pop),
        .rx_mac_tdata   (rx_mac_tdata),
        .rx_mac_tkeep   (rx_mac_tkeep),
        .rx_mac_tuser   (rx_mac_tuser),
        .rx_mac_tlast   (rx_mac_tlast),
        .rx_mac_tvalid  (rx_mac_tvalid),
        .rx_mac_tready  (rx_mac_tready)
    );

endmodule

//--- verif/tb_mac_axis.sv
`timescale 1ns/10ps

module tb_mac_axis;
    import mac_axis_pkg::*;

    localparam int CLK_HALF  = 10;
    localparam int NUM_TESTS = 6;
    localparam int MAX_WORDS = 8;
    localparam int WD_CYCLES = NUM_TESTS * MAX_WORDS * 40;
    localparam int RX_MEM    = 256;

    // Expected receive beat
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
        logic [LEN_W-1:0]  tuser;
    } rx_exp_t;

    // DUT ports
    logic              Reset;
    logic              MAC_rx_clk_div;
    logic [DATA_W-1:0] tx_mac_tdata;
    logic [KEEP_W-1:0] tx_mac_tkeep;
    logic              tx_mac_tlast;
    logic              tx_mac_tvalid;
    logic              tx_mac_tready;
    logic [DATA_W-1:0] rx_mac_tdata;
    logic [KEEP_W-1:0] rx_mac_tkeep;
    logic [LEN_W-1:0]  rx_mac_tuser;
    logic              rx_mac_tlast;
    logic              rx_mac_tvalid;
    logic              rx_mac_tready = 1'b1;
    mac_beat_t         mac_tx_beat;
    logic              mac_tx_wr;
    logic              mac_tx_wa = 1'b1;
    mac_beat_t         mac_rx_beat;
    logic              mac_rx_pa;
    logic              mac_rx_rd;
    rx_status_t        mac_rx_status;
    logic              rx_append_crc;

    // MAC model word store, head is the word on show
    mac_beat_t   rx_mem [RX_MEM];
    int          rx_head  = 0;
    int          rx_tail  = 0;
    logic        rx_take  = 1'b0;
    int          frame_id = 0;

    // Scoreboard
    mac_beat_t   tx_exp_q [$];
    rx_exp_t     rx_exp_q [$];
    int          tx_beats = 0;
    int          tx_words = 0;
    int          rx_beats = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       test_name;

    // Random back-pressure
    logic [31:0] lfsr  = 32'h3d6f_5eff;
    logic        tx_bp = 1'b0;
    logic        rx_bp = 1'b0;

    logic [KEEP_W-1:0] keep_list [4] = '{4'hf, 4'he, 4'hc, 4'h8};
    mac_be_e           be_list [4]   = '{be_four, be_three, be_two, be_one};

    mac_axis mac_axis_inst (.*);

    // ************************************************************************
    // Reference model
    // ************************************************************************

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int be_bytes(input mac_be_e be);
        case (be)
            be_three: return 3;
            be_two:   return 2;
            be_one:   return 1;
            default:  return 4;
        endcase
    endfunction

    // Run of valid bytes from the top lane down
    function automatic mac_be_e ref_be(input logic [KEEP_W-1:0] keep);
        int n;
        n = 0;
        while (n < KEEP_W && keep[KEEP_W-1-n]) begin
            n++;
        end
        case (n)
            1:       return be_one;
            2:       return be_two;
            3:       return be_three;
            default: return be_four;
        endcase
    endfunction

    // Leading ones, one per valid byte
    function automatic logic [KEEP_W-1:0] ref_keep(input mac_be_e be);
        logic [KEEP_W-1:0] ones;
        ones = '1;
        return ~(ones >> be_bytes(be));
    endfunction

    function automatic logic [LEN_W-1:0] ref_tuser(input logic [LEN_W-1:0] len,
                                                  input logic append_crc);
        return append_crc ? len : len - LEN_W'(CRC_BYTES);
    endfunction

    // ************************************************************************
    // Checks and test bookkeeping
    // ************************************************************************

    task automatic check_val(input string sig, input logic [31:0] got, input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            test_errors++;
            $display("FAIL %s got %h exp %h", sig, got, want);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            test_errors++;
            $display("Error in %s: %s", test_name, what);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic finish_test();
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s", tests_run, test_name, (test_errors == 0) ? "ok" : "errors");
    endtask

    task automatic next_cycle();
        @(posedge Reset);
        #2;
    endtask

    // Both expected queues empty, then a quiet spell
    task automatic drain();
        while (tx_exp_q.size() != 0 || rx_exp_q.size() != 0) begin
            next_cycle();
        end
        repeat (10) next_cycle();
    endtask

    // ************************************************************************
    // Stimulus
    // ************************************************************************

    // One AXI-stream packet, each beat held until taken
    task automatic send_tx_packet(input int pkt, input int nbeats, input logic [KEEP_W-1:0] last_keep);
        mac_beat_t word;
        logic      taken;
        for (int b = 0; b < nbeats; b++) begin
            tx_mac_tdata  = {8'h5a, 8'(pkt), 8'(b), 8'(pkt * 7 + b)};
            tx_mac_tkeep  = (b == nbeats - 1) ? last_keep : '1;
            tx_mac_tlast  = (b == nbeats - 1);
            tx_mac_tvalid = 1'b1;
            word.data = tx_mac_tdata;
            word.be   = ref_be(tx_mac_tkeep);
            word.sop  = (b == 0);
            word.eop  = tx_mac_tlast;
            tx_exp_q.push_back(word);
            taken = 1'b0;
            while (!taken) begin
                @(negedge Reset);
                taken = tx_mac_tready;
                next_cycle();
            end
            tx_beats++;
        end
        tx_mac_tvalid = 1'b0;
    endtask

    // Store a frame in the MAC model, then pulse status apply
    task automatic load_rx_frame(input int nwords, input mac_be_e last_be, input rx_err_e err,
                                 input int apply_cycles);
        mac_beat_t        word;
        rx_exp_t          e;
        logic [LEN_W-1:0] len;
        len = LEN_W'((nwords - 1) * 4 + be_bytes(last_be));
        // MAC length counts the FCS even when it is stripped
        if (!rx_append_crc) begin
            len = len + LEN_W'(CRC_BYTES);
        end
        // Bad frames never reach the MAC data FIFO
        if (err == rx_good) begin
            for (int i = 0; i < nwords; i++) begin
                word.data = {8'hc3, 8'(frame_id), 8'(i), 8'hff - 8'(i)};
                word.be   = (i == nwords - 1) ? last_be : be_four;
                word.sop  = (i == 0);
                word.eop  = (i == nwords - 1);
                rx_mem[rx_tail] = word;
                rx_tail++;
                e.data  = word.data;
                e.keep  = ref_keep(word.be);
                e.last  = word.eop;
                e.tuser = ref_tuser(len, rx_append_crc);
                rx_exp_q.push_back(e);
            end
        end
        frame_id++;
        mac_rx_status.apply    = 1'b1;
        mac_rx_status.err_type = err;
        mac_rx_status.length   = len;
        repeat (apply_cycles) next_cycle();
        mac_rx_status.apply = 1'b0;
        // Gap so the next apply shows a fresh edge
        repeat (2) next_cycle();
    endtask

    // ************************************************************************
    // Clock, MAC model and compare
    // ************************************************************************

    initial begin
        Reset = 1'b0;
        forever begin
            #CLK_HALF;
            Reset = ~Reset;
        end
    end

    // FWFT MAC, word valid in the read cycle
    assign mac_rx_beat = rx_mem[rx_head];
    assign mac_rx_pa   = mac_rx_rd && (rx_head != rx_tail);

    always @(posedge Reset) begin
        #2;
        if (rx_take) begin
            rx_head++;
        end
    end

    // Flags latched on the edge, drive after the delay
    always @(posedge Reset) begin : drive_backpressure
        logic tx_en;
        logic rx_en;
        tx_en = tx_bp;
        rx_en = rx_bp;
        #2;
        if (tx_en) begin
            lfsr      = lfsr_step(lfsr);
            mac_tx_wa = lfsr[0];
        end else begin
            mac_tx_wa = 1'b1;
        end
        if (rx_en) begin
            lfsr          = lfsr_step(lfsr);
            rx_mac_tready = lfsr[0];
        end else begin
            rx_mac_tready = 1'b1;
        end
    end

    // Mid-cycle sampling, all inputs settled
    always @(negedge Reset) begin : compare_beats
        mac_beat_t txe;
        rx_exp_t   rxe;
        rx_take = mac_rx_rd && mac_rx_pa;
        if (!MAC_rx_clk_div) begin
            check_val("tx_mac_tready", tx_mac_tready, mac_tx_wa);
            check_val("mac_tx_wr", mac_tx_wr, tx_mac_tvalid && mac_tx_wa);
            if (mac_tx_wr) begin
                tx_words++;
                check_true(tx_exp_q.size() != 0, "legacy transmit word with no beat offered");
                if (tx_exp_q.size() != 0) begin
                    txe = tx_exp_q.pop_front();
                    check_val("mac_tx_beat.data", mac_tx_beat.data, txe.data);
                    check_val("mac_tx_beat.be", mac_tx_beat.be, txe.be);
                    check_val("mac_tx_beat.sop", mac_tx_beat.sop, txe.sop);
                    check_val("mac_tx_beat.eop", mac_tx_beat.eop, txe.eop);
                end
            end
            check_true(!(mac_rx_rd && rx_exp_q.size() == 0),
                       "receive read strobe with no frame pending");
            if (rx_mac_tvalid && rx_mac_tready) begin
                rx_beats++;
                check_true(rx_exp_q.size() != 0, "receive beat with no frame pending");
                if (rx_exp_q.size() != 0) begin
                    rxe = rx_exp_q.pop_front();
                    check_val("rx_mac_tdata", rx_mac_tdata, rxe.data);
                    check_val("rx_mac_tkeep", rx_mac_tkeep, rxe.keep);
                    check_val("rx_mac_tlast", rx_mac_tlast, rxe.last);
                    check_val("rx_mac_tuser", rx_mac_tuser, rxe.tuser);
                end
            end
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge Reset);
        $display("Timeout: run did not finish within %0d cycles", WD_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    // ************************************************************************
    // Test sequence
    // ************************************************************************

    initial begin : run_tests
        int total;
        MAC_rx_clk_div = 1'b1;
        tx_mac_tdata   = '0;
        tx_mac_tkeep   = '0;
        tx_mac_tlast   = 1'b0;
        tx_mac_tvalid  = 1'b0;
        mac_rx_status  = '0;
        rx_append_crc  = 1'b0;
        for (int i = 0; i < RX_MEM; i++) begin
            rx_mem[i] = '0;
        end
        repeat (10) @(posedge Reset);
        #2;
        MAC_rx_clk_div = 1'b0;
        repeat (2) next_cycle();

        // Every tkeep on the last beat, single-beat packets too
        start_test("transmit mapping");
        for (int k = 0; k < 16; k++) begin
            send_tx_packet(k, 1 + k % 3, 4'(k));
        end
        drain();
        finish_test();

        start_test("transmit back-pressure");
        tx_beats = 0;
        tx_words = 0;
        tx_bp    = 1'b1;
        for (int k = 0; k < 10; k++) begin
            send_tx_packet(16 + k, 1 + k % 4, keep_list[k % 4]);
        end
        drain();
        tx_bp = 1'b0;
        check_val("tx_word_count", tx_words, tx_beats);
        finish_test();

        start_test("receive with CRC strip");
        rx_append_crc = 1'b0;
        for (int f = 0; f < 5; f++) begin
            load_rx_frame(1 + f, be_list[f % 4], rx_good, 1);
        end
        drain();
        finish_test();

        // Long apply pulses, one length each
        start_test("receive with CRC kept");
        rx_append_crc = 1'b1;
        for (int f = 0; f < 4; f++) begin
            load_rx_frame(2 + f, be_list[(f + 1) % 4], rx_good, 2 + f);
        end
        drain();
        finish_test();

        start_test("error frames filtered");
        rx_append_crc = 1'b0;
        rx_beats      = 0;
        load_rx_frame(4, be_four, err_crc, 1);
        load_rx_frame(MAX_WORDS, be_two, err_too_long, 2);
        load_rx_frame(1, be_one, err_too_short, 1);
        load_rx_frame(3, be_three, err_fifo_full, 3);
        repeat (20) next_cycle();
        check_val("rx_beat_count", rx_beats, 0);
        load_rx_frame(3, be_two, rx_good, 1);
        drain();
        check_val("rx_beat_count", rx_beats, 3);
        finish_test();

        // Frames queue up faster than they drain
        start_test("receive back-pressure");
        rx_beats = 0;
        total    = 0;
        rx_bp    = 1'b1;
        for (int f = 0; f < 6; f++) begin
            load_rx_frame(MAX_WORDS - f, be_list[f % 4], rx_good, 1);
            total += MAX_WORDS - f;
        end
        drain();
        rx_bp = 1'b0;
        check_val("rx_beat_count", rx_beats, total);
        finish_test();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_run == NUM_TESTS) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
rtl/mac_axis_pkg.sv
rtl/axis_tx_adapter.sv
rtl/axis_rx_adapter.sv
rtl/rx_length_queue.sv
rtl/mac_axis.sv
verif/tb_mac_axis.sv

//--- Makefile
# Verilator build and run of the AXI-stream MAC shim testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_mac_axis
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
